//--- hdl/wiener_consts.svh
`ifndef WIENER_CONSTS_SVH
`define WIENER_CONSTS_SVH

// bus and pixel widths
`define WR_ADDR_W 32
`define WR_PIX_W 8
`define WR_DATA_W 32

// tile geometry, side must be a power of two
`define WR_BLOCK 8
`define WR_BLOCK_LOG2 3

// AR field encodings
`define WR_SIZE_4B 3'd2 // four-byte beat
`define WR_BURST_INCR 2'd1 // incrementing burst

`endif

//--- hdl/wiener_pkg.sv
`include "wiener_consts.svh"

package wiener_pkg;

	// one word of memory address, in pixel units
	typedef logic [`WR_ADDR_W-1:0] addr_t;

	// frame height or width, up to 720 x 1280
	typedef logic [15:0] dim_t;

	typedef logic [`WR_PIX_W-1:0] pix_t;

	// per-tile statistics for the Wiener stage
	typedef struct packed {
		pix_t mean;
		logic [15:0] variance; // mean of squares minus squared mean
	} block_stats_t;

endpackage

//--- hdl/rd_cmd_if.sv
`timescale 1ns/1ns

interface rd_cmd_if (
	input logic clk
);

	logic start_read; // one-cycle strobe
	wiener_pkg::addr_t read_addr;
	logic [8:0] read_len; // beats per burst, not minus one
	logic [1:0] read_burst;

	modport reader (
		input clk,
		output start_read,
		output read_addr,
		output read_len,
		output read_burst
	);

	modport master (
		input clk,
		input start_read,
		input read_addr,
		input read_len,
		input read_burst
	);

endinterface

//--- hdl/memory_reader_wiener.sv
`timescale 1ns/1ns
`include "wiener_consts.svh"

module memory_reader_wiener #(
	parameter int BLOCK_SIZE = `WR_BLOCK
) (
	input logic clk,
	input logic rst_n,
	input wiener_pkg::dim_t frame_height,
	input wiener_pkg::dim_t frame_width,
	input wiener_pkg::addr_t base_addr,
	input logic noise_ready,
	input logic beat_valid,
	input logic beat_last,
	input logic stats_valid,
	rd_cmd_if.reader cmd,
	output logic start_of_frame,
	output logic end_of_frame,
	output logic frame_done
);

	localparam int BL = $clog2(BLOCK_SIZE);

	typedef enum logic [1:0] {
		IDLE,
		WAIT_DATA, // burst issued, first beat not seen yet
		READ,
		FRAME_READY // waiting for the last tile's statistics
	} state_t;

	state_t state;

	logic [BL-1:0] pixel_x; // beat inside the burst
	logic [BL-1:0] pixel_y; // pixel row inside the tile
	wiener_pkg::dim_t col;
	wiener_pkg::dim_t row;
	wiener_pkg::dim_t width_q;
	wiener_pkg::dim_t height_q;
	wiener_pkg::dim_t tiles_x;
	wiener_pkg::dim_t tiles_y;
	wiener_pkg::dim_t next_line;
	wiener_pkg::dim_t next_col;
	wiener_pkg::addr_t base_q;
	wiener_pkg::addr_t addr_hold;
	wiener_pkg::addr_t next_addr;

	logic last_x;
	logic last_y;
	logic last_col;
	logic last_row;
	logic beat_ok;
	logic frame_last;
	logic first_beat;

	assign tiles_x = width_q >> BL;
	assign tiles_y = height_q >> BL;

	assign last_x = pixel_x == BL'(BLOCK_SIZE - 1);
	assign last_y = pixel_y == BL'(BLOCK_SIZE - 1);
	assign last_col = col == tiles_x - 16'd1;
	assign last_row = row == tiles_y - 16'd1;

	assign beat_ok = beat_valid && (state == WAIT_DATA || state == READ);
	assign frame_last = beat_ok && beat_last && last_y && last_col && last_row;
	assign first_beat = beat_ok && pixel_x == '0 && pixel_y == '0 && col == '0 && row == '0;

	// burst shape never changes
	assign cmd.read_len = 9'(BLOCK_SIZE);
	assign cmd.read_burst = `WR_BURST_INCR;

	// pixel row and column where the following burst starts
	always_comb begin
		if (!last_y) begin
			next_line = (row << BL) + wiener_pkg::dim_t'(pixel_y) + 16'd1;
			next_col = col << BL;
		end else if (!last_col) begin
			next_line = row << BL; // next tile to the right
			next_col = (col + 16'd1) << BL;
		end else begin
			next_line = (row + 16'd1) << BL;
			next_col = '0;
		end
	end

	assign next_addr = base_q + wiener_pkg::addr_t'(next_line) * wiener_pkg::addr_t'(width_q)
		+ wiener_pkg::addr_t'(next_col);

	always_ff @(posedge clk) begin
		if (state == IDLE && noise_ready) begin
			base_q <= base_addr;
			width_q <= frame_width;
			height_q <= frame_height;
			cmd.read_addr <= base_addr;
		end
		if (beat_ok && pixel_x == BL'(BLOCK_SIZE - 2))
			addr_hold <= next_addr; // ready one beat before beat_last
		if (beat_ok && beat_last && !frame_last)
			cmd.read_addr <= addr_hold;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			cmd.start_read <= 1'b0;
			start_of_frame <= 1'b0;
			end_of_frame <= 1'b0;
			frame_done <= 1'b0;
			pixel_x <= '0;
			pixel_y <= '0;
			col <= '0;
			row <= '0;
		end else begin
			cmd.start_read <= 1'b0;
			start_of_frame <= first_beat;
			end_of_frame <= frame_last;
			frame_done <= 1'b0;

			case (state)
				IDLE: begin
					pixel_x <= '0;
					pixel_y <= '0;
					col <= '0;
					row <= '0;
					if (noise_ready) begin
						cmd.start_read <= 1'b1; // first burst at the frame base
						state <= WAIT_DATA;
					end
				end
				WAIT_DATA, READ: begin
					if (beat_ok) begin
						state <= READ;
						if (frame_last)
							state <= FRAME_READY;
						else if (beat_last) begin
							cmd.start_read <= 1'b1;
							state <= WAIT_DATA;
						end
					end
				end
				FRAME_READY: begin
					if (stats_valid) begin
						frame_done <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase

			// walk x, then y, then tile column, then tile row
			if (beat_ok) begin
				if (!last_x)
					pixel_x <= pixel_x + 1'b1;
				else begin
					pixel_x <= '0;
					if (!last_y)
						pixel_y <= pixel_y + 1'b1;
					else begin
						pixel_y <= '0;
						if (!last_col)
							col <= col + 16'd1;
						else begin
							col <= '0;
							row <= last_row ? '0 : row + 16'd1;
						end
					end
				end
			end
		end
	end

endmodule

//--- hdl/axi_read_master.sv
`timescale 1ns/1ns
`include "wiener_consts.svh"

module axi_read_master (
	input logic clk,
	input logic rst_n,
	rd_cmd_if.master cmd,
	input logic arready,
	input logic rvalid,
	input logic [`WR_DATA_W-1:0] rdata,
	input logic rlast,
	output logic arvalid,
	output wiener_pkg::addr_t araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic beat_valid,
	output logic beat_last,
	output wiener_pkg::pix_t beat_pix
);

	logic [8:0] len_m1;

	assign len_m1 = cmd.read_len - 9'd1; // AXI length is beats minus one

	// AR valid, held until the slave takes it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			arvalid <= 1'b0;
		else if (cmd.start_read)
			arvalid <= 1'b1;
		else if (arready)
			arvalid <= 1'b0;
	end

	// AR payload, captured on the strobe only
	always_ff @(posedge clk) begin
		if (cmd.start_read) begin
			araddr <= cmd.read_addr;
			arlen <= len_m1[7:0];
			arsize <= `WR_SIZE_4B;
			arburst <= cmd.read_burst;
		end
	end

	// R channel has no back-pressure, beats go straight through
	assign beat_valid = rvalid;
	assign beat_last = rvalid && rlast;
	assign beat_pix = rdata[`WR_PIX_W-1:0]; // pixel sits in the low byte

endmodule

//--- hdl/block_stats.sv
`timescale 1ns/1ns
`include "wiener_consts.svh"

module block_stats (
	input logic clk,
	input logic rst_n,
	input logic beat_valid,
	input wiener_pkg::pix_t beat_pix,
	output logic stats_valid,
	output wiener_pkg::block_stats_t stats
);

	localparam int CNT_W = 2 * `WR_BLOCK_LOG2; // log2 of pixels per tile
	localparam int SUM_W = `WR_PIX_W + CNT_W;
	localparam int SQ_W = 2 * `WR_PIX_W + CNT_W;

	logic [CNT_W-1:0] count; // wraps once per tile
	logic [SUM_W-1:0] sum;
	logic [SQ_W-1:0] sum_sq;

	logic [2*`WR_PIX_W-1:0] pix_wide;
	logic [2*`WR_PIX_W-1:0] pix_sq;
	logic [SUM_W-1:0] sum_n;
	logic [SQ_W-1:0] sq_n;
	logic [2*`WR_PIX_W-1:0] mean_w;
	logic [2*`WR_PIX_W-1:0] mean_pow;
	logic [2*`WR_PIX_W-1:0] mean_sq;

	assign pix_wide = {{`WR_PIX_W{1'b0}}, beat_pix};
	assign pix_sq = pix_wide * pix_wide;

	// totals including the current beat
	assign sum_n = sum + SUM_W'(beat_pix);
	assign sq_n = sum_sq + SQ_W'(pix_sq);

	// divide by the pixel count with a shift
	assign mean_w = {{`WR_PIX_W{1'b0}}, sum_n[SUM_W-1:CNT_W]};
	assign mean_pow = mean_w * mean_w;
	assign mean_sq = sq_n[SQ_W-1:CNT_W];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
			sum <= '0;
			sum_sq <= '0;
			stats_valid <= 1'b0;
		end else begin
			stats_valid <= 1'b0;
			if (beat_valid) begin
				count <= count + 1'b1;
				if (&count) begin
					sum <= '0; // tile complete, restart
					sum_sq <= '0;
					stats_valid <= 1'b1;
				end else begin
					sum <= sum_n;
					sum_sq <= sq_n;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (beat_valid && &count) begin
			stats.mean <= sum_n[SUM_W-1:CNT_W];
			stats.variance <= mean_sq - mean_pow;
		end
	end

endmodule

//--- hdl/wiener_reader_top.sv
`timescale 1ns/1ns
`include "wiener_consts.svh"

module wiener_reader_top (
	input logic clk,
	input logic rst_n,
	input wiener_pkg::dim_t frame_height,
	input wiener_pkg::dim_t frame_width,
	input wiener_pkg::addr_t base_addr,
	input logic noise_ready,
	input logic arready,
	input logic rvalid,
	input logic [`WR_DATA_W-1:0] rdata,
	input logic rlast,
	output logic arvalid,
	output wiener_pkg::addr_t araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic start_of_frame,
	output logic end_of_frame,
	output logic frame_done,
	output logic stats_valid,
	output wiener_pkg::block_stats_t stats
);

	logic beat_valid;
	logic beat_last;
	wiener_pkg::pix_t beat_pix;

	rd_cmd_if cmd_if (.clk(clk));

	memory_reader_wiener reader_i (
		.clk(clk),
		.rst_n(rst_n),
		.frame_height(frame_height),
		.frame_width(frame_width),
		.base_addr(base_addr),
		.noise_ready(noise_ready),
		.beat_valid(beat_valid),
		.beat_last(beat_last),
		.stats_valid(stats_valid),
		.cmd(cmd_if.reader),
		.start_of_frame(start_of_frame),
		.end_of_frame(end_of_frame),
		.frame_done(frame_done)
	);

	axi_read_master master_i (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd_if.master),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rlast(rlast),
		.arvalid(arvalid),
		.araddr(araddr),
		.arlen(arlen),
		.arsize(arsize),
		.arburst(arburst),
		.beat_valid(beat_valid),
		.beat_last(beat_last),
		.beat_pix(beat_pix)
	);

	block_stats stats_i (
		.clk(clk),
		.rst_n(rst_n),
		.beat_valid(beat_valid),
		.beat_pix(beat_pix),
		.stats_valid(stats_valid),
		.stats(stats)
	);

endmodule

//--- test/wiener_reader_assert.sv
`timescale 1ns/1ns

module wiener_reader_assert (
	input logic clk,
	input logic rst_n,
	input logic arvalid,
	input logic arready,
	input wiener_pkg::addr_t araddr,
	input logic start_read,
	input logic beat_valid,
	input logic beat_last,
	input logic start_of_frame,
	input logic end_of_frame
);

	logic burst_open; // open from strobe to last beat

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			burst_open <= 1'b0;
		else if (start_read)
			burst_open <= 1'b1;
		else if (beat_valid && beat_last)
			burst_open <= 1'b0;
	end

	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid or araddr changed before arready");

	no_early_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		start_read |-> !burst_open)
		else $error("start_read issued while a burst was still open");

	sof_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		start_of_frame |=> !start_of_frame)
		else $error("start_of_frame held longer than one cycle");

	eof_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		end_of_frame |=> !end_of_frame)
		else $error("end_of_frame held longer than one cycle");

endmodule

bind wiener_reader_top wiener_reader_assert top_assert_i (
	.clk(clk),
	.rst_n(rst_n),
	.arvalid(arvalid),
	.arready(arready),
	.araddr(araddr),
	.start_read(cmd_if.start_read),
	.beat_valid(beat_valid),
	.beat_last(beat_last),
	.start_of_frame(start_of_frame),
	.end_of_frame(end_of_frame)
);

//--- test/tb_wiener_reader.sv
`timescale 1ns/1ns
`include "wiener_consts.svh"

module tb_wiener_reader;

	localparam int BLK = `WR_BLOCK;
	localparam int TILE_PIX = BLK * BLK;
	localparam int TOTAL_BURSTS = 32 + 32 + 24; // three frames
	localparam int CYCLE_LIMIT = TOTAL_BURSTS * 40 + 200;

	logic clk;
	logic rst_n;
	wiener_pkg::dim_t frame_height;
	wiener_pkg::dim_t frame_width;
	wiener_pkg::addr_t base_addr;
	logic noise_ready;
	logic arready;
	logic rvalid;
	logic [`WR_DATA_W-1:0] rdata;
	logic rlast;
	logic arvalid;
	wiener_pkg::addr_t araddr;
	logic [7:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic start_of_frame;
	logic end_of_frame;
	logic frame_done;
	logic stats_valid;
	wiener_pkg::block_stats_t stats;

	integer seed;
	int cycle_count;
	int addr_errors;
	int stats_errors;
	int bit_errors;
	logic random_mode; // memory inserts random stalls

	// observations of the current frame
	wiener_pkg::addr_t ar_seen[$];
	wiener_pkg::block_stats_t stats_seen[$];
	int stats_cycle[$];
	int sof_count;
	int eof_count;
	int done_count;
	int sof_cycle;
	int eof_cycle;
	int done_cycle;
	int last_beat_cycle;
	logic ar_after_done;

	wiener_reader_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.frame_height(frame_height),
		.frame_width(frame_width),
		.base_addr(base_addr),
		.noise_ready(noise_ready),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rlast(rlast),
		.arvalid(arvalid),
		.araddr(araddr),
		.arlen(arlen),
		.arsize(arsize),
		.arburst(arburst),
		.start_of_frame(start_of_frame),
		.end_of_frame(end_of_frame),
		.frame_done(frame_done),
		.stats_valid(stats_valid),
		.stats(stats)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: DUT did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	// registered outputs sampled mid-cycle
	always @(negedge clk) begin
		if (stats_valid) begin
			stats_seen.push_back(stats);
			stats_cycle.push_back(cycle_count);
		end
		if (start_of_frame) begin
			sof_count++;
			sof_cycle = cycle_count;
		end
		if (end_of_frame) begin
			eof_count++;
			eof_cycle = cycle_count;
		end
		if (frame_done) begin
			done_count++;
			done_cycle = cycle_count;
		end
		if (arvalid && done_count > 0)
			ar_after_done = 1'b1;
	end

	function automatic wiener_pkg::pix_t model_pix(input wiener_pkg::addr_t a);
		return a[7:0] ^ a[15:8];
	endfunction

	// first pixel of one tile row
	function automatic wiener_pkg::addr_t burst_addr(input wiener_pkg::addr_t base,
		input int width, input int trow, input int tcol, input int prow);
		return base + wiener_pkg::addr_t'((trow * BLK + prow) * width + tcol * BLK);
	endfunction

	function automatic wiener_pkg::block_stats_t expected_stats(input wiener_pkg::addr_t base,
		input int width, input int trow, input int tcol);
		wiener_pkg::block_stats_t s;
		int sum;
		int sum_sq;
		int mean;
		int p;
		sum = 0;
		sum_sq = 0;
		for (int y = 0; y < BLK; y++) begin
			for (int x = 0; x < BLK; x++) begin
				p = model_pix(burst_addr(base, width, trow, tcol, y) + wiener_pkg::addr_t'(x));
				sum += p;
				sum_sq += p * p;
			end
		end
		mean = sum / TILE_PIX;
		s.mean = wiener_pkg::pix_t'(mean);
		s.variance = 16'(sum_sq / TILE_PIX - mean * mean);
		return s;
	endfunction

	task automatic check_addr(input wiener_pkg::addr_t got, input wiener_pkg::addr_t exp,
		input string what);
		if (got !== exp) begin
			addr_errors++;
			$display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_stats(input wiener_pkg::block_stats_t got,
		input wiener_pkg::block_stats_t exp, input string what);
		if (got !== exp) begin
			stats_errors++;
			$display("FAILED at %0t ns: %s, got mean %0d var %0d expected mean %0d var %0d",
				$time, what, got.mean, got.variance, exp.mean, exp.variance);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			bit_errors++;
			$display("FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
		end
	endtask

	// AXI slave model serving one burst per call
	task automatic serve_burst();
		wiener_pkg::addr_t a;
		wiener_pkg::addr_t pa;
		int stall;
		int k;
		while (!arvalid)
			@(negedge clk);
		stall = random_mode ? $unsigned($random(seed)) % 4 : 0;
		repeat (stall) @(negedge clk);
		a = araddr;
		ar_seen.push_back(a);
		check_bit(arlen == 8'(BLK - 1) && arsize == 3'd2 && arburst == 2'd1, 1'b1,
			"AR burst shape");
		arready = 1'b1;
		@(negedge clk);
		arready = 1'b0;
		for (k = 0; k < BLK; k++) begin
			stall = random_mode ? $unsigned($random(seed)) % 3 : 0;
			repeat (stall) @(negedge clk);
			pa = a + wiener_pkg::addr_t'(k);
			rvalid = 1'b1;
			rdata = {pa[`WR_DATA_W-`WR_PIX_W-1:0], model_pix(pa)}; // junk above the pixel
			rlast = k == BLK - 1;
			if (k == BLK - 1)
				last_beat_cycle = cycle_count;
			@(negedge clk);
			rvalid = 1'b0;
			rlast = 1'b0;
		end
	endtask

	task automatic test_reset_idle();
		repeat (5) begin
			@(negedge clk);
			check_bit(arvalid, 1'b0, "arvalid idle after reset");
			check_bit(start_of_frame, 1'b0, "start_of_frame idle after reset");
			check_bit(end_of_frame, 1'b0, "end_of_frame idle after reset");
			check_bit(frame_done, 1'b0, "frame_done idle after reset");
			check_bit(stats_valid, 1'b0, "stats_valid idle after reset");
		end
	endtask

	task automatic test_frame(input int height, input int width, input wiener_pkg::addr_t base,
		input logic rnd);
		int tiles_x;
		int tiles_y;
		int idx;
		int tr;
		int tc;
		int p;
		tiles_x = width / BLK;
		tiles_y = height / BLK;
		random_mode = rnd;
		ar_seen.delete();
		stats_seen.delete();
		stats_cycle.delete();
		sof_count = 0;
		eof_count = 0;
		done_count = 0;
		ar_after_done = 1'b0;

		@(negedge clk);
		frame_height = wiener_pkg::dim_t'(height);
		frame_width = wiener_pkg::dim_t'(width);
		base_addr = base;
		noise_ready = 1'b1;
		@(negedge clk);
		noise_ready = 1'b0;
		check_bit(arvalid, 1'b0, "arvalid one cycle after noise_ready");
		@(negedge clk);
		check_bit(arvalid, 1'b1, "arvalid two cycles after noise_ready");

		while (!frame_done)
			@(negedge clk);
		repeat (10) @(negedge clk); // watch for stray requests
		@(posedge clk);

		check_bit(ar_seen.size() == tiles_x * tiles_y * BLK, 1'b1, "burst count");
		idx = 0;
		for (tr = 0; tr < tiles_y; tr++)
			for (tc = 0; tc < tiles_x; tc++)
				for (p = 0; p < BLK; p++) begin
					if (idx < ar_seen.size())
						check_addr(ar_seen[idx], burst_addr(base, width, tr, tc, p), "araddr");
					idx++;
				end

		check_bit(stats_seen.size() == tiles_x * tiles_y, 1'b1, "stats_valid count");
		idx = 0;
		for (tr = 0; tr < tiles_y; tr++)
			for (tc = 0; tc < tiles_x; tc++) begin
				if (idx < stats_seen.size())
					check_stats(stats_seen[idx], expected_stats(base, width, tr, tc), "tile stats");
				idx++;
			end

		check_bit(sof_count == 1, 1'b1, "one start_of_frame");
		check_bit(eof_count == 1, 1'b1, "one end_of_frame");
		check_bit(done_count == 1, 1'b1, "one frame_done");
		if (stats_cycle.size() > 0) begin
			check_bit(sof_cycle < stats_cycle[0], 1'b1, "start_of_frame before first stats");
			check_bit(stats_cycle[$] == last_beat_cycle + 1, 1'b1, "last stats after last beat");
		end
		check_bit(eof_cycle == last_beat_cycle + 1, 1'b1, "end_of_frame after last beat");
		check_bit(done_cycle == eof_cycle + 1, 1'b1, "frame_done after end_of_frame");
		check_bit(ar_after_done, 1'b0, "no arvalid after frame_done");
	endtask

	initial begin
		seed = 32'h28fb;
		addr_errors = 0;
		stats_errors = 0;
		bit_errors = 0;
		random_mode = 1'b0;
		last_beat_cycle = 0;
		rst_n = 1'b0;
		frame_height = '0;
		frame_width = '0;
		base_addr = '0;
		noise_ready = 1'b0;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rlast = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		fork
			forever serve_burst();
		join_none

		test_reset_idle();
		test_frame(16, 16, 32'h0000_1040, 1'b0);
		test_frame(16, 16, 32'h0002_3a10, 1'b1);
		test_frame(8, 24, 32'h0000_7f00, 1'b1); // three tiles in one row

		$display("errors: address %0d, statistics %0d, signal %0d",
			addr_errors, stats_errors, bit_errors);
		if (addr_errors + stats_errors + bit_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- build.f
+incdir+hdl
hdl/wiener_pkg.sv
hdl/rd_cmd_if.sv
hdl/memory_reader_wiener.sv
hdl/axi_read_master.sv
hdl/block_stats.sv
hdl/wiener_reader_top.sv
test/wiener_reader_assert.sv
test/tb_wiener_reader.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module tb_wiener_reader -o tb_wiener_reader

status=0
output=$(./obj_dir/tb_wiener_reader) || status=$?
echo "$output"

if echo "$output" | grep -q "Test completed successfully"; then
	exit 0
fi
echo "simulation did not report success, exit status $status"
exit 1
